// File: hw/controlUnit_consts.svh
`ifndef CONTROLUNIT_CONSTS_SVH
`define CONTROLUNIT_CONSTS_SVH

// machine registers, one mask bit each.
`define REG_COUNT 14

// instruction byte and its argument field.
`define INSN_WIDTH 8
`define ARG_WIDTH 5

// fixed register positions inside the masks.
`define REG_PC 0
`define REG_IR 1
`define REG_AC 13

// reset argument that clears every register after IR.
`define ARG_ALL 31

`endif

// File: hw/controlUnitPkg.sv
`include "controlUnit_consts.svh"

package controlUnitPkg;

	// instruction class in the top three bits of the byte.
	typedef enum logic [2:0] {
		clsReset,
		clsInc,
		clsMove,
		clsLoad,
		clsStore,
		clsAlu,
		clsJump,
		clsHalt
	} insnClass_e;

	typedef struct packed {
		insnClass_e cls;
		logic [`ARG_WIDTH-1:0] arg;
	} insnFields_t;

	// a fetched byte is an instruction or, after a jump, a raw target.
	typedef union packed {
		insnFields_t fields;
		logic [`INSN_WIDTH-1:0] raw;
	} insnWord_u;

	typedef enum logic [2:0] {
		aluNone,
		aluAdd,
		aluMul,
		aluDiv,
		aluMod
	} aluOp_e;

	// bus source driven during a strobe.
	typedef enum logic [2:0] {
		busAc,
		busMemOut,
		busAddr,
		busMulr,
		busWv
	} busSel_e;

endpackage

// File: hw/insnFetch.sv
`timescale 1ns/100ps
`include "controlUnit_consts.svh"

module insnFetch (
	input logic clk,
	input logic reset,
	input logic fetchStart,
	output logic fetchDone,
	output controlUnitPkg::insnWord_u insnWord,
	output logic iReq,
	input logic iAck,
	input logic [`INSN_WIDTH-1:0] iData
);

	typedef enum logic [1:0] {
		fIdle,
		fReq,
		fRelease
	} fetchState_e;

	fetchState_e state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fIdle;
			iReq <= 1'b0;
			fetchDone <= 1'b0;
		end else begin
			fetchDone <= 1'b0;
			case (state)
				fIdle: begin
					if (fetchStart) begin
						iReq <= 1'b1;
						state <= fReq;
					end
				end
				fReq: begin
					// drop the request on the first acknowledge.
					if (iAck) begin
						iReq <= 1'b0;
						state <= fRelease;
					end
				end
				fRelease: begin
					if (!iAck) begin
						fetchDone <= 1'b1;
						state <= fIdle;
					end
				end
				default: state <= fIdle;
			endcase
		end
	end

	// byte is captured while iAck is first seen high.
	always_ff @(posedge clk) begin
		if (state == fReq && iAck) begin
			insnWord.raw <= iData;
		end
	end

	// request must wait for the memory.
	assert property (@(posedge clk) disable iff (reset) iReq && !iAck |=> iReq)
		else $error("iReq fell before iAck");

endmodule

// File: hw/dataPort.sv
`timescale 1ns/100ps

module dataPort (
	input logic clk,
	input logic reset,
	input logic dataStart,
	input logic dataWrite,
	output logic dataDone,
	output logic dReq,
	output logic dWrite,
	input logic dAck
);

	typedef enum logic [1:0] {
		pIdle,
		pReq,
		pRelease
	} portState_e;

	portState_e state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pIdle;
			dReq <= 1'b0;
			dWrite <= 1'b0;
			dataDone <= 1'b0;
		end else begin
			dataDone <= 1'b0;
			case (state)
				pIdle: begin
					// direction is fixed for the whole transfer.
					if (dataStart) begin
						dReq <= 1'b1;
						dWrite <= dataWrite;
						state <= pReq;
					end
				end
				pReq: begin
					if (dAck) begin
						dReq <= 1'b0;
						state <= pRelease;
					end
				end
				pRelease: begin
					if (!dAck) begin
						dataDone <= 1'b1;
						state <= pIdle;
					end
				end
				default: state <= pIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) dReq |=> (!dReq || $stable(dWrite)))
		else $error("dWrite changed under dReq");

	// sequencer waits for dataDone before the next transfer.
	assert property (@(posedge clk) disable iff (reset) dataStart |-> state == pIdle)
		else $error("dataStart during an open transfer");

endmodule

// File: hw/microSequencer.sv
`timescale 1ns/100ps
`include "controlUnit_consts.svh"

module microSequencer (
	input logic clk,
	input logic reset,
	output logic fetchStart,
	input logic fetchDone,
	input controlUnitPkg::insnWord_u insnWord,
	output logic dataStart,
	output logic dataWrite,
	input logic dataDone,
	input logic z1,
	input logic z2,
	output logic ctrlValid,
	output controlUnitPkg::aluOp_e aluOp,
	output controlUnitPkg::busSel_e busSel,
	output logic [`REG_COUNT-1:0] wrtEn,
	output logic [`REG_COUNT-1:0] incEn,
	output logic [`REG_COUNT-1:0] rstEn,
	output logic [`INSN_WIDTH-1:0] jumpTarget,
	output logic busy
);

	typedef enum logic [2:0] {
		sFetch,
		sDecode,
		sDataWait,
		sTargetFetch,
		sHalted
	} seqState_e;

	localparam logic [`REG_COUNT-1:0] oneBit = {{(`REG_COUNT-1){1'b0}}, 1'b1};
	localparam logic [`REG_COUNT-1:0] pcMask = oneBit << `REG_PC;
	localparam logic [`REG_COUNT-1:0] irMask = oneBit << `REG_IR;
	// registers after IR up to AC.
	localparam logic [`REG_COUNT-1:0] allMask =
		{{(`REG_AC - `REG_IR){1'b1}}, {(`REG_IR + 1){1'b0}}};

	seqState_e state;
	controlUnitPkg::insnFields_t insn;
	logic reqOpen;
	logic jumpTaken;
	logic [`REG_COUNT-1:0] argMask;
	logic [`REG_COUNT-1:0] rstMask;
	controlUnitPkg::aluOp_e aluOpSel;
	controlUnitPkg::busSel_e aluBusSel;

	// each state visit starts at most one memory transfer.
	assign fetchStart = (state == sFetch || state == sTargetFetch) && !reqOpen;
	assign dataStart = (state == sDataWait) && !reqOpen;
	assign dataWrite = (insn.cls == controlUnitPkg::clsStore);

	assign argMask = (insn.arg < `REG_COUNT) ? (oneBit << insn.arg) : '0;
	assign rstMask = (insn.arg == `ARG_ALL) ? allMask : argMask;

	// 0 always, 1 on z1, 2 on z2 low, 3 never.
	always_comb begin
		case (insn.arg[1:0])
			2'd0: jumpTaken = 1'b1;
			2'd1: jumpTaken = z1;
			2'd2: jumpTaken = !z2;
			default: jumpTaken = 1'b0;
		endcase
	end

	always_comb begin
		case (insn.arg[1:0])
			2'd0: begin
				aluOpSel = controlUnitPkg::aluAdd;
				aluBusSel = controlUnitPkg::busAddr;
			end
			2'd1: begin
				aluOpSel = controlUnitPkg::aluMul;
				aluBusSel = controlUnitPkg::busMulr;
			end
			2'd2: begin
				aluOpSel = controlUnitPkg::aluDiv;
				aluBusSel = controlUnitPkg::busWv;
			end
			default: begin
				aluOpSel = controlUnitPkg::aluMod;
				aluBusSel = controlUnitPkg::busWv;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == sFetch && fetchDone) begin
			insn <= insnWord.fields;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sFetch;
			reqOpen <= 1'b0;
			ctrlValid <= 1'b0;
			aluOp <= controlUnitPkg::aluNone;
			busSel <= controlUnitPkg::busAc;
			wrtEn <= '0;
			incEn <= '0;
			rstEn <= '0;
			jumpTarget <= '0;
			busy <= 1'b1;
		end else begin
			// strobes last one cycle.
			ctrlValid <= 1'b0;
			aluOp <= controlUnitPkg::aluNone;
			busSel <= controlUnitPkg::busAc;
			wrtEn <= '0;
			incEn <= '0;
			rstEn <= '0;
			jumpTarget <= '0;
			if (fetchStart || dataStart) begin
				reqOpen <= 1'b1;
			end else if (fetchDone || dataDone) begin
				reqOpen <= 1'b0;
			end
			case (state)
				sFetch: begin
					if (fetchDone) begin
						ctrlValid <= 1'b1;
						incEn <= pcMask;
						wrtEn <= irMask;
						state <= sDecode;
					end
				end
				sDecode: begin
					state <= sFetch;
					case (insn.cls)
						controlUnitPkg::clsReset: begin
							ctrlValid <= 1'b1;
							rstEn <= rstMask;
						end
						controlUnitPkg::clsInc: begin
							ctrlValid <= 1'b1;
							incEn <= argMask;
						end
						controlUnitPkg::clsMove: begin
							ctrlValid <= 1'b1;
							wrtEn <= argMask;
						end
						controlUnitPkg::clsLoad, controlUnitPkg::clsStore: state <= sDataWait;
						controlUnitPkg::clsAlu: begin
							ctrlValid <= 1'b1;
							aluOp <= aluOpSel;
							busSel <= aluBusSel;
						end
						controlUnitPkg::clsJump: begin
							// not taken skips the target byte.
							if (jumpTaken) begin
								state <= sTargetFetch;
							end else begin
								ctrlValid <= 1'b1;
								incEn <= pcMask;
								wrtEn <= irMask;
							end
						end
						default: begin
							busy <= 1'b0;
							state <= sHalted;
						end
					endcase
				end
				sDataWait: begin
					if (dataDone) begin
						ctrlValid <= 1'b1;
						if (insn.cls == controlUnitPkg::clsLoad) begin
							wrtEn <= argMask;
							busSel <= controlUnitPkg::busMemOut;
						end
						state <= sFetch;
					end
				end
				sTargetFetch: begin
					if (fetchDone) begin
						ctrlValid <= 1'b1;
						wrtEn <= pcMask;
						jumpTarget <= insnWord.raw;
						state <= sFetch;
					end
				end
				sHalted: state <= sHalted;
				default: state <= sFetch;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) ctrlValid |-> busy)
		else $error("ctrlValid while halted");

	// a mask names one register unless it is the reset-all.
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(wrtEn) && $onehot0(incEn) && ($onehot0(rstEn) || rstEn == allMask))
		else $error("mask has more than one bit set");

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/100ps
`include "controlUnit_consts.svh"

module controlUnit (
	input logic clk,
	input logic reset,
	output logic iReq,
	input logic iAck,
	input logic [`INSN_WIDTH-1:0] iData,
	output logic dReq,
	output logic dWrite,
	input logic dAck,
	input logic z1,
	input logic z2,
	output logic ctrlValid,
	output controlUnitPkg::aluOp_e aluOp,
	output controlUnitPkg::busSel_e busSel,
	output logic [`REG_COUNT-1:0] wrtEn,
	output logic [`REG_COUNT-1:0] incEn,
	output logic [`REG_COUNT-1:0] rstEn,
	output logic [`INSN_WIDTH-1:0] jumpTarget,
	output logic busy
);

	logic fetchStart;
	logic fetchDone;
	controlUnitPkg::insnWord_u insnWord;
	logic dataStart;
	logic dataWrite;
	logic dataDone;

	insnFetch u_insnFetch (
		.clk(clk),
		.reset(reset),
		.fetchStart(fetchStart),
		.fetchDone(fetchDone),
		.insnWord(insnWord),
		.iReq(iReq),
		.iAck(iAck),
		.iData(iData)
	);

	microSequencer u_microSequencer (
		.clk(clk),
		.reset(reset),
		.fetchStart(fetchStart),
		.fetchDone(fetchDone),
		.insnWord(insnWord),
		.dataStart(dataStart),
		.dataWrite(dataWrite),
		.dataDone(dataDone),
		.z1(z1),
		.z2(z2),
		.ctrlValid(ctrlValid),
		.aluOp(aluOp),
		.busSel(busSel),
		.wrtEn(wrtEn),
		.incEn(incEn),
		.rstEn(rstEn),
		.jumpTarget(jumpTarget),
		.busy(busy)
	);

	dataPort u_dataPort (
		.clk(clk),
		.reset(reset),
		.dataStart(dataStart),
		.dataWrite(dataWrite),
		.dataDone(dataDone),
		.dReq(dReq),
		.dWrite(dWrite),
		.dAck(dAck)
	);

endmodule

// File: verif/controlUnitTb.sv
`timescale 1ns/100ps
`include "controlUnit_consts.svh"

module controlUnitTb;

	localparam int progLen = 32;
	// a byte never needs more than about 15 cycles with acknowledge delays up to 3.
	localparam int cycleLimit = 40 * progLen + 10 + 50;

	typedef logic [`REG_COUNT-1:0] regMask_t;

	typedef struct packed {
		regMask_t wrt;
		regMask_t inc;
		regMask_t rst;
		controlUnitPkg::aluOp_e alu;
		controlUnitPkg::busSel_e bus;
		logic [`INSN_WIDTH-1:0] target;
		logic [1:0] xfer;
		logic haltFetch;
	} strobeExp_t;

	logic clk;
	logic reset;
	logic iReq;
	logic iAck;
	logic [`INSN_WIDTH-1:0] iData;
	logic dReq;
	logic dWrite;
	logic dAck;
	logic z1;
	logic z2;
	logic ctrlValid;
	controlUnitPkg::aluOp_e aluOp;
	controlUnitPkg::busSel_e busSel;
	regMask_t wrtEn;
	regMask_t incEn;
	regMask_t rstEn;
	logic [`INSN_WIDTH-1:0] jumpTarget;
	logic busy;

	// the class sits in bits 7:5 and the argument in 4:0; an operand byte follows each jump.
	logic [`INSN_WIDTH-1:0] progMem [progLen] = '{
		8'h05, 8'h1f, 8'h14, 8'h2d, 8'h22, 8'h47, 8'h4f, 8'h63,
		8'h6d, 8'h80, 8'ha0, 8'ha1, 8'ha2, 8'ha3, 8'hc1, 8'h55,
		8'hc1, 8'h13, 8'he0, 8'hc2, 8'h00, 8'hc2, 8'h18, 8'he0,
		8'hc3, 8'h00, 8'hc0, 8'h1d, 8'he0, 8'he0, 8'he0, 8'he0
	};
	// flag levels seen by the instruction at each address.
	localparam logic [progLen-1:0] z1Map = 32'h0101_0000;
	localparam logic [progLen-1:0] z2Map = 32'h0008_0000;

	integer seed = 32'ha081;
	strobeExp_t expQ[$];
	logic [4:0] fetchAddrQ[$];
	logic fetchOpQ[$];
	strobeExp_t want;
	logic prevIReq = 1'b0;
	logic prevIAck = 1'b0;
	logic prevDReq = 1'b0;
	logic prevDAck = 1'b0;
	logic prevDWrite = 1'b0;
	logic [1:0] xferDir = 2'd0;
	logic [1:0] xferDone = 2'd0;
	int strobeCount = 0;
	int chkFetchIdx = 0;
	logic haltNext = 1'b0;
	logic halted = 1'b0;
	int imIdx = 0;
	logic [4:0] servedAddr;
	logic servedOp;
	int cycles = 0;

	controlUnit u_controlUnit (.*);

	always #10 clk = ~clk;

	task automatic failRun();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("Fail time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
			failRun();
		end
	endtask

	task automatic requireTrue(input bit cond, input string why);
		assert (cond) else begin
			$display("%s at time %0t", why, $time);
			failRun();
		end
	endtask

	function automatic int pickAckDelay();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	function automatic regMask_t maskAt(input logic [4:0] idx);
		return (idx < `REG_COUNT) ? (regMask_t'(1) << idx) : '0;
	endfunction

	function automatic strobeExp_t emptyStrobe();
		strobeExp_t s;
		s = '0;
		s.alu = controlUnitPkg::aluNone;
		s.bus = controlUnitPkg::busAc;
		return s;
	endfunction

	// walks the program the way the machine should and lists fetches and strobes.
	task automatic buildExpected();
		logic [4:0] pc;
		logic [4:0] opAddr;
		logic [`INSN_WIDTH-1:0] op;
		logic [4:0] arg;
		logic taken;
		logic done;
		int steps;
		strobeExp_t s;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < progLen) begin
			opAddr = pc;
			op = progMem[pc];
			arg = op[4:0];
			fetchAddrQ.push_back(pc);
			fetchOpQ.push_back(1'b1);
			s = emptyStrobe();
			s.inc = maskAt(`REG_PC);
			s.wrt = maskAt(`REG_IR);
			s.haltFetch = (op[7:5] == controlUnitPkg::clsHalt);
			expQ.push_back(s);
			pc = pc + 5'd1;
			s = emptyStrobe();
			case (controlUnitPkg::insnClass_e'(op[7:5]))
				controlUnitPkg::clsReset: begin
					// reset-all clears everything but PC and IR.
					if (arg == `ARG_ALL) begin
						s.rst = ~(maskAt(`REG_PC) | maskAt(`REG_IR));
					end else begin
						s.rst = maskAt(arg);
					end
				end
				controlUnitPkg::clsInc: s.inc = maskAt(arg);
				controlUnitPkg::clsMove: s.wrt = maskAt(arg);
				controlUnitPkg::clsLoad: begin
					s.xfer = 2'd1;
					s.wrt = maskAt(arg);
					s.bus = controlUnitPkg::busMemOut;
				end
				controlUnitPkg::clsStore: s.xfer = 2'd2;
				controlUnitPkg::clsAlu: begin
					case (arg[1:0])
						2'd0: begin
							s.alu = controlUnitPkg::aluAdd;
							s.bus = controlUnitPkg::busAddr;
						end
						2'd1: begin
							s.alu = controlUnitPkg::aluMul;
							s.bus = controlUnitPkg::busMulr;
						end
						2'd2: begin
							s.alu = controlUnitPkg::aluDiv;
							s.bus = controlUnitPkg::busWv;
						end
						default: begin
							s.alu = controlUnitPkg::aluMod;
							s.bus = controlUnitPkg::busWv;
						end
					endcase
				end
				controlUnitPkg::clsJump: begin
					case (arg[1:0])
						2'd0: taken = 1'b1;
						2'd1: taken = z1Map[opAddr];
						2'd2: taken = !z2Map[opAddr];
						default: taken = 1'b0;
					endcase
					if (taken) begin
						fetchAddrQ.push_back(pc);
						fetchOpQ.push_back(1'b0);
						s.wrt = maskAt(`REG_PC);
						s.target = progMem[pc];
						pc = progMem[pc][4:0];
					end else begin
						s.inc = maskAt(`REG_PC);
						s.wrt = maskAt(`REG_IR);
						pc = pc + 5'd1;
					end
				end
				default: done = 1'b1;
			endcase
			if (!done) begin
				expQ.push_back(s);
			end
			steps++;
		end
	endtask

	// the instruction memory answers each request with the next predicted byte.
	always begin
		@(posedge clk);
		if (iReq && !reset) begin
			servedAddr = (imIdx < fetchAddrQ.size()) ? fetchAddrQ[imIdx] : '0;
			servedOp = (imIdx < fetchOpQ.size()) ? fetchOpQ[imIdx] : 1'b0;
			imIdx++;
			repeat (pickAckDelay()) @(posedge clk);
			#1;
			iAck = 1'b1;
			iData = progMem[servedAddr];
			if (servedOp) begin
				z1 = z1Map[servedAddr];
				z2 = z2Map[servedAddr];
			end
			@(posedge clk);
			while (iReq) begin
				@(posedge clk);
			end
			repeat (pickAckDelay()) @(posedge clk);
			#1;
			iAck = 1'b0;
		end
	end

	always begin
		@(posedge clk);
		if (dReq && !reset) begin
			repeat (pickAckDelay()) @(posedge clk);
			#1;
			dAck = 1'b1;
			@(posedge clk);
			while (dReq) begin
				@(posedge clk);
			end
			repeat (pickAckDelay()) @(posedge clk);
			#1;
			dAck = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			requireTrue(!(prevIReq && !iReq) || prevIAck, "iReq fell before iAck was high");
			requireTrue(!(!prevIReq && iReq) || !iAck, "iReq rose while iAck was still high");
			requireTrue(!(prevDReq && !dReq) || prevDAck, "dReq fell before dAck was high");
			requireTrue(!(!prevDReq && dReq) || !dAck, "dReq rose while dAck was still high");
			if (prevDReq && dReq) begin
				checkEq("dWrite", 16'(prevDWrite), 16'(dWrite));
			end
			if (!prevDReq && dReq) begin
				xferDir = dWrite ? 2'd2 : 2'd1;
			end
			if (prevDAck && !dAck) begin
				xferDone = xferDir;
			end
			if (!prevIReq && iReq) begin
				requireTrue(chkFetchIdx < fetchOpQ.size(), "instruction fetch nobody predicted");
				if (fetchOpQ[chkFetchIdx]) begin
					if (chkFetchIdx != 0) begin
						checkEq("strobes per instruction", 16'd2, 16'(strobeCount));
					end
					strobeCount = 0;
				end
				chkFetchIdx++;
			end
			if (haltNext) begin
				halted = 1'b1;
				haltNext = 1'b0;
			end
			if (halted) begin
				checkEq("busy", 16'd0, 16'(busy));
			end else begin
				checkEq("busy", 16'd1, 16'(busy));
			end
			if (ctrlValid) begin
				requireTrue(expQ.size() != 0, "control strobe nobody predicted");
				want = expQ.pop_front();
				checkEq("wrtEn", 16'(want.wrt), 16'(wrtEn));
				checkEq("incEn", 16'(want.inc), 16'(incEn));
				checkEq("rstEn", 16'(want.rst), 16'(rstEn));
				checkEq("aluOp", 16'(want.alu), 16'(aluOp));
				checkEq("busSel", 16'(want.bus), 16'(busSel));
				checkEq("jumpTarget", 16'(want.target), 16'(jumpTarget));
				checkEq("data transfer", 16'(want.xfer), 16'(xferDone));
				xferDone = 2'd0;
				strobeCount++;
				haltNext = want.haltFetch;
			end else begin
				// between strobes every field rests at its idle value.
				checkEq("wrtEn", 16'd0, 16'(wrtEn));
				checkEq("incEn", 16'd0, 16'(incEn));
				checkEq("rstEn", 16'd0, 16'(rstEn));
				checkEq("aluOp", 16'(controlUnitPkg::aluNone), 16'(aluOp));
				checkEq("busSel", 16'(controlUnitPkg::busAc), 16'(busSel));
				checkEq("jumpTarget", 16'd0, 16'(jumpTarget));
			end
		end
		prevIReq = iReq;
		prevIAck = iAck;
		prevDReq = dReq;
		prevDAck = dAck;
		prevDWrite = dWrite;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("run timed out after %0d cycles", cycleLimit);
			failRun();
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		iAck = 1'b0;
		iData = '0;
		dAck = 1'b0;
		z1 = 1'b0;
		z2 = 1'b0;
		buildExpected();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		checkEq("ctrlValid", 16'd0, 16'(ctrlValid));
		checkEq("iReq", 16'd0, 16'(iReq));
		checkEq("dReq", 16'd0, 16'(dReq));
		checkEq("wrtEn", 16'd0, 16'(wrtEn));
		checkEq("incEn", 16'd0, 16'(incEn));
		checkEq("rstEn", 16'd0, 16'(rstEn));
		checkEq("busy", 16'd1, 16'(busy));
		@(posedge clk);
		#1;
		checkEq("iReq", 16'd1, 16'(iReq));
		wait (halted);
		// the monitor flags any request or strobe in this quiet window.
		repeat (50) @(posedge clk);
		if (expQ.size() == 0 && chkFetchIdx == fetchAddrQ.size()) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("halted with predicted strobes or fetches still outstanding");
			failRun();
		end
	end

endmodule

// File: files.f
+incdir+hw
hw/controlUnitPkg.sv
hw/insnFetch.sv
hw/dataPort.sv
hw/microSequencer.sv
hw/controlUnit.sv
verif/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the simulation stops on $fatal.
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f files.f \
		--top-module controlUnitTb -o controlUnitSim &&
	./obj_dir/controlUnitSim ||
	{ echo "build or simulation failed"; exit 1; }
